//--- verilog/snoop_pkg.sv
/*
  Shared widths, snoop codes and channel payloads for the snoop side of the
  coherent data cache. Every stage and the top level import this package.
  The address union lets stages index by line address while the ports carry
  the raw byte address.
*/
package snoop_pkg;

  localparam int ADDR_W      = 32;
  localparam int LINE_W      = 128;
  localparam int BEAT_W      = 64;
  localparam int OFFSET_W    = 4;
  localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

  // ACE AC snoop codes served here
  typedef enum logic [3:0] {
    SNP_READ_ONCE     = 4'b0000,
    SNP_READ_SHARED   = 4'b0001,
    SNP_READ_UNIQUE   = 4'b0111,
    SNP_CLEAN_INVALID = 4'b1001
  } snoop_e;

  typedef struct packed {
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [OFFSET_W-1:0]    offset;
  } snoop_line_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    snoop_line_t       line;
  } snoop_addr_u;

  typedef struct packed {
    snoop_addr_u addr;
    snoop_e      snoop;
  } ac_req_t;

  typedef struct packed {
    logic data_transfer;
    logic error;
    logic pass_dirty;
    logic is_shared;
    logic was_unique;
  } cr_resp_t;

  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic              last;
  } cd_beat_t;

  typedef struct packed {
    logic                   valid;
    logic [LINE_ADDR_W-1:0] line_addr;
    snoop_e                 snoop;
    logic                   bypass;
  } snoop_cmd_t;

  // way is wide enough for any associativity
  typedef struct packed {
    logic                   valid;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [7:0]             way;
    logic [LINE_W-1:0]      data;
    logic                   dirty;
    logic                   shared;
  } fill_req_t;

  typedef struct packed {
    logic                   valid;
    logic [LINE_ADDR_W-1:0] line_addr;
  } inv_note_t;

  typedef struct packed {
    logic              valid;
    cr_resp_t          resp;
    logic [LINE_W-1:0] line;
  } resp_item_t;

endpackage

//--- verilog/snoop_accept.sv
/*
  AC channel stage. Takes one snoop request at a time and registers it as a
  command for the evaluate stage. AC is held off while the local side works
  on the same line or a fill to that line is present, and the bypass input
  is sampled together with the request.
*/
module snoop_accept (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       ac_valid_i,
  input  snoop_pkg::ac_req_t                         ac_i,
  output logic                                       ac_ready_o,
  input  logic                                       bypass_i,
  input  logic                                       local_busy_i,
  input  logic [snoop_pkg::LINE_ADDR_W-1:0]          local_line_i,
  input  snoop_pkg::fill_req_t                       fill_i,
  output snoop_pkg::snoop_cmd_t                      cmd_o,
  input  logic                                       cmd_ready_i
);
  import snoop_pkg::*;

  snoop_cmd_t             cmd_q;
  logic [LINE_ADDR_W-1:0] ac_line;
  logic                   local_hit;
  logic                   fill_hit;
  logic                   slot_free;
  logic                   ac_fire;

  // stages compare by line, not by byte
  assign ac_line = ac_i.addr.line.line_addr;

  assign local_hit = local_busy_i && (local_line_i == ac_line);
  assign fill_hit  = fill_i.valid && (fill_i.line_addr == ac_line);

  // register empty, or emptied by eval in this cycle
  assign slot_free  = !cmd_q.valid || cmd_ready_i;
  assign ac_ready_o = slot_free && !local_hit && !fill_hit;
  assign ac_fire    = ac_valid_i && ac_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
    end else if (ac_fire) begin
      cmd_q.valid     <= 1'b1;
      cmd_q.line_addr <= ac_line;
      cmd_q.snoop     <= ac_i.snoop;
      cmd_q.bypass    <= bypass_i;
    end else if (cmd_ready_i) begin
      cmd_q.valid <= 1'b0;
    end
  end

  assign cmd_o = cmd_q;

endmodule

//--- verilog/cache_store.sv
/*
  Tag, state and data arrays of the set-associative cache.
  The fill port installs a whole way. A lookup compares the tag in every way
  and returns the hit, dirty and shared vectors and the hit line one cycle
  later. The update port acts on the set of the most recent lookup.
*/
module cache_store #(
  parameter int NUM_SETS = 8,
  parameter int NUM_WAYS = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  snoop_pkg::fill_req_t              fill_i,
  input  logic                              lookup_i,
  input  logic [snoop_pkg::LINE_ADDR_W-1:0] lookup_line_i,
  output logic [NUM_WAYS-1:0]               hit_way_o,
  output logic [NUM_WAYS-1:0]               dirty_way_o,
  output logic [NUM_WAYS-1:0]               shared_way_o,
  output logic [snoop_pkg::LINE_W-1:0]      line_o,
  input  logic                              upd_valid_i,
  input  logic [NUM_WAYS-1:0]               upd_way_i,
  input  logic                              upd_invalidate_i,
  input  logic                              upd_shared_i
);
  import snoop_pkg::*;

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = LINE_ADDR_W - IDX_W;

  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] shared_q;
  logic [TAG_W-1:0]                  tag_q  [NUM_SETS][NUM_WAYS];
  logic [LINE_W-1:0]                 data_q [NUM_SETS][NUM_WAYS];

  logic [IDX_W-1:0]    fill_idx;
  logic [TAG_W-1:0]    fill_tag;
  logic [IDX_W-1:0]    look_idx;
  logic [TAG_W-1:0]    look_tag;
  logic [IDX_W-1:0]    upd_idx_q;
  logic [NUM_WAYS-1:0] hit_d;
  logic [LINE_W-1:0]   line_d;

  assign fill_idx = fill_i.line_addr[IDX_W-1:0];
  assign fill_tag = fill_i.line_addr[LINE_ADDR_W-1:IDX_W];
  assign look_idx = lookup_line_i[IDX_W-1:0];
  assign look_tag = lookup_line_i[LINE_ADDR_W-1:IDX_W];

  // tag compare in all ways, then select the hit line
  always_comb begin
    hit_d  = '0;
    line_d = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_d[w] = valid_q[look_idx][w] && (tag_q[look_idx][w] == look_tag);
      if (hit_d[w]) begin
        line_d = data_q[look_idx][w];
      end
    end
  end

  // state bits; a fill wins over an update in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      shared_q <= '0;
    end else if (fill_i.valid) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (fill_i.way == 8'(w)) begin
          valid_q[fill_idx][w]  <= 1'b1;
          dirty_q[fill_idx][w]  <= fill_i.dirty;
          shared_q[fill_idx][w] <= fill_i.shared;
        end
      end
    end else if (upd_valid_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (upd_way_i[w] && upd_invalidate_i) begin
          valid_q[upd_idx_q][w]  <= 1'b0;
          dirty_q[upd_idx_q][w]  <= 1'b0;
          shared_q[upd_idx_q][w] <= 1'b0;
        end else if (upd_way_i[w] && upd_shared_i) begin
          shared_q[upd_idx_q][w] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i.valid) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (fill_i.way == 8'(w)) begin
          tag_q[fill_idx][w]  <= fill_tag;
          data_q[fill_idx][w] <= fill_i.data;
        end
      end
    end
  end

  // registered lookup result, held until the next lookup
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      upd_idx_q    <= look_idx;
      hit_way_o    <= hit_d;
      dirty_way_o  <= dirty_q[look_idx] & hit_d;
      shared_way_o <= shared_q[look_idx] & hit_d;
      line_o       <= line_d;
    end
  end

endmodule

//--- verilog/snoop_eval.sv
/*
  Evaluate stage. Takes a command, looks the line up in the store, builds
  the CR flags and hands one item to the response stage. The state update
  (set shared or invalidate) is written in the handover cycle; a fill in
  that cycle has priority and the handover waits. Bypassed and unsupported
  snoops skip the lookup.
*/
module snoop_eval #(
  parameter int NUM_SETS = 8,
  parameter int NUM_WAYS = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  snoop_pkg::snoop_cmd_t             cmd_i,
  output logic                              cmd_ready_o,
  output logic                              lookup_o,
  output logic [snoop_pkg::LINE_ADDR_W-1:0] lookup_line_o,
  input  logic [NUM_WAYS-1:0]               hit_way_i,
  input  logic [NUM_WAYS-1:0]               dirty_way_i,
  input  logic [NUM_WAYS-1:0]               shared_way_i,
  input  logic [snoop_pkg::LINE_W-1:0]      line_i,
  output logic                              upd_valid_o,
  output logic [NUM_WAYS-1:0]               upd_way_o,
  output logic                              upd_invalidate_o,
  output logic                              upd_shared_o,
  input  logic                              fill_valid_i,
  output snoop_pkg::inv_note_t              inv_o,
  output snoop_pkg::resp_item_t             item_o,
  input  logic                              item_ready_i
);
  import snoop_pkg::*;

  localparam int IDX_W = $clog2(NUM_SETS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_EVAL,
    S_HAND
  } state_e;

  state_e                       state_q;
  logic                         inv_q;
  logic                         shr_q;
  snoop_e                       snoop_q;
  logic [IDX_W-1:0]             set_q;
  logic [LINE_ADDR_W-IDX_W-1:0] tag_q;
  logic [NUM_WAYS-1:0]          way_q;
  cr_resp_t                     resp_q;
  logic [LINE_W-1:0]            line_q;

  logic     take;
  logic     supported;
  logic     hit;
  logic     dirty;
  logic     shared;
  cr_resp_t eval_resp;
  logic     eval_inv;
  logic     eval_shr;
  logic     hold;
  logic     hand;

  assign cmd_ready_o = (state_q == S_IDLE);
  assign take        = cmd_ready_o && cmd_i.valid;

  assign supported = cmd_i.snoop inside {SNP_READ_ONCE, SNP_READ_SHARED,
                                         SNP_READ_UNIQUE, SNP_CLEAN_INVALID};

  assign lookup_o      = take && supported && !cmd_i.bypass;
  assign lookup_line_o = cmd_i.line_addr;

  assign hit    = |hit_way_i;
  assign dirty  = |(dirty_way_i & hit_way_i);
  assign shared = |(shared_way_i & hit_way_i);

  // response rules on a hit; a miss leaves every flag low
  always_comb begin
    eval_resp = '0;
    eval_inv  = 1'b0;
    eval_shr  = 1'b0;
    if (hit) begin
      case (snoop_q)
        SNP_READ_ONCE: begin
          eval_resp.data_transfer = 1'b1;
          eval_resp.is_shared     = shared;
        end
        SNP_READ_SHARED: begin
          eval_resp.data_transfer = 1'b1;
          eval_resp.is_shared     = 1'b1;
          eval_shr                = 1'b1;
        end
        SNP_READ_UNIQUE: begin
          eval_resp.data_transfer = 1'b1;
          eval_resp.pass_dirty    = dirty;
          eval_inv                = 1'b1;
        end
        default: begin
          eval_resp.data_transfer = dirty;
          eval_resp.pass_dirty    = dirty;
          eval_inv                = 1'b1;
        end
      endcase
    end
  end

  // a pending update cannot share its cycle with a fill
  assign hold = fill_valid_i && (inv_q || shr_q);
  assign hand = (state_q == S_HAND) && !hold && item_ready_i;

  assign item_o.valid = (state_q == S_HAND) && !hold;
  assign item_o.resp  = resp_q;
  assign item_o.line  = line_q;

  assign upd_valid_o      = hand && (inv_q || shr_q);
  assign upd_way_o        = way_q;
  assign upd_invalidate_o = inv_q;
  assign upd_shared_o     = shr_q;

  assign inv_o.valid     = hand && inv_q;
  assign inv_o.line_addr = {tag_q, set_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      inv_q   <= 1'b0;
      shr_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          inv_q <= 1'b0;
          shr_q <= 1'b0;
          if (take) begin
            state_q <= lookup_o ? S_EVAL : S_HAND;
          end
        end
        S_EVAL: begin
          inv_q   <= eval_inv;
          shr_q   <= eval_shr;
          state_q <= S_HAND;
        end
        default: begin
          if (hand) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      snoop_q <= cmd_i.snoop;
      set_q   <= cmd_i.line_addr[IDX_W-1:0];
      tag_q   <= cmd_i.line_addr[LINE_ADDR_W-1:IDX_W];
      // bypass wins over an unsupported code
      resp_q       <= '0;
      resp_q.error <= !supported && !cmd_i.bypass;
      line_q       <= '0;
    end else if (state_q == S_EVAL) begin
      resp_q <= eval_resp;
      line_q <= line_i;
      way_q  <= hit_way_i;
    end
  end

endmodule

//--- verilog/snoop_resp.sv
/*
  CR and CD channel stage. Holds one response item, drives CR and, when
  data is transferred, sends the line as two 64-bit beats, low half first.
  CR and the beats may complete in either order; the item is released once
  both are done.
*/
module snoop_resp (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  snoop_pkg::resp_item_t item_i,
  output logic                  item_ready_o,
  output logic                  cr_valid_o,
  output snoop_pkg::cr_resp_t   cr_o,
  input  logic                  cr_ready_i,
  output logic                  cd_valid_o,
  output snoop_pkg::cd_beat_t   cd_o,
  input  logic                  cd_ready_i
);
  import snoop_pkg::*;

  logic              busy_q;
  logic              cr_done_q;
  logic              beat_q;
  logic              cd_done_q;
  cr_resp_t          resp_q;
  logic [LINE_W-1:0] line_q;

  logic cr_fire;
  logic cd_fire;
  logic cr_ok;
  logic cd_ok;
  logic done;

  assign item_ready_o = !busy_q;

  assign cr_valid_o = busy_q && !cr_done_q;
  assign cr_o       = resp_q;

  assign cd_valid_o = busy_q && resp_q.data_transfer && !cd_done_q;
  assign cd_o.data  = beat_q ? line_q[LINE_W-1:BEAT_W] : line_q[BEAT_W-1:0];
  assign cd_o.last  = beat_q;

  assign cr_fire = cr_valid_o && cr_ready_i;
  assign cd_fire = cd_valid_o && cd_ready_i;

  // each channel is complete when taken now or earlier
  assign cr_ok = cr_done_q || cr_fire;
  assign cd_ok = !resp_q.data_transfer || cd_done_q || (cd_fire && beat_q);
  assign done  = busy_q && cr_ok && cd_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      cr_done_q <= 1'b0;
      beat_q    <= 1'b0;
      cd_done_q <= 1'b0;
    end else if (item_i.valid && item_ready_o) begin
      busy_q    <= 1'b1;
      cr_done_q <= 1'b0;
      beat_q    <= 1'b0;
      cd_done_q <= 1'b0;
    end else if (done) begin
      busy_q <= 1'b0;
    end else begin
      cr_done_q <= cr_ok;
      beat_q    <= beat_q || cd_fire;
      cd_done_q <= cd_done_q || (cd_fire && beat_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (item_i.valid && item_ready_o) begin
      resp_q <= item_i.resp;
      line_q <= item_i.line;
    end
  end

endmodule

//--- verilog/snoop_subsys_top.sv
/*
  Top level of the snoop side. Chains the accept, evaluate and response
  stages around the cache store and sets the array geometry. The local
  side reaches it only through the fill port, the busy line and the
  invalidate notice.
*/
module snoop_subsys_top #(
  parameter int NUM_SETS = 8,
  parameter int NUM_WAYS = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ac_valid_i,
  input  snoop_pkg::ac_req_t                ac_i,
  output logic                              ac_ready_o,
  output logic                              cr_valid_o,
  output snoop_pkg::cr_resp_t               cr_o,
  input  logic                              cr_ready_i,
  output logic                              cd_valid_o,
  output snoop_pkg::cd_beat_t               cd_o,
  input  logic                              cd_ready_i,
  input  snoop_pkg::fill_req_t              fill_i,
  input  logic                              local_busy_i,
  input  logic [snoop_pkg::LINE_ADDR_W-1:0] local_line_i,
  output snoop_pkg::inv_note_t              inv_o,
  input  logic                              bypass_i
);
  import snoop_pkg::*;

  snoop_cmd_t             cmd;
  logic                   cmd_ready;
  logic                   lookup;
  logic [LINE_ADDR_W-1:0] lookup_line;
  logic [NUM_WAYS-1:0]    hit_way;
  logic [NUM_WAYS-1:0]    dirty_way;
  logic [NUM_WAYS-1:0]    shared_way;
  logic [LINE_W-1:0]      line;
  logic                   upd_valid;
  logic [NUM_WAYS-1:0]    upd_way;
  logic                   upd_invalidate;
  logic                   upd_shared;
  resp_item_t             item;
  logic                   item_ready;

  snoop_accept u_snoop_accept (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ac_valid_i   (ac_valid_i),
    .ac_i         (ac_i),
    .ac_ready_o   (ac_ready_o),
    .bypass_i     (bypass_i),
    .local_busy_i (local_busy_i),
    .local_line_i (local_line_i),
    .fill_i       (fill_i),
    .cmd_o        (cmd),
    .cmd_ready_i  (cmd_ready)
  );

  snoop_eval #(
    .NUM_SETS (NUM_SETS),
    .NUM_WAYS (NUM_WAYS)
  ) u_snoop_eval (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_i            (cmd),
    .cmd_ready_o      (cmd_ready),
    .lookup_o         (lookup),
    .lookup_line_o    (lookup_line),
    .hit_way_i        (hit_way),
    .dirty_way_i      (dirty_way),
    .shared_way_i     (shared_way),
    .line_i           (line),
    .upd_valid_o      (upd_valid),
    .upd_way_o        (upd_way),
    .upd_invalidate_o (upd_invalidate),
    .upd_shared_o     (upd_shared),
    .fill_valid_i     (fill_i.valid),
    .inv_o            (inv_o),
    .item_o           (item),
    .item_ready_i     (item_ready)
  );

  cache_store #(
    .NUM_SETS (NUM_SETS),
    .NUM_WAYS (NUM_WAYS)
  ) u_cache_store (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fill_i           (fill_i),
    .lookup_i         (lookup),
    .lookup_line_i    (lookup_line),
    .hit_way_o        (hit_way),
    .dirty_way_o      (dirty_way),
    .shared_way_o     (shared_way),
    .line_o           (line),
    .upd_valid_i      (upd_valid),
    .upd_way_i        (upd_way),
    .upd_invalidate_i (upd_invalidate),
    .upd_shared_i     (upd_shared)
  );

  snoop_resp u_snoop_resp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .item_i       (item),
    .item_ready_o (item_ready),
    .cr_valid_o   (cr_valid_o),
    .cr_o         (cr_o),
    .cr_ready_i   (cr_ready_i),
    .cd_valid_o   (cd_valid_o),
    .cd_o         (cd_o),
    .cd_ready_i   (cd_ready_i)
  );

endmodule

//--- dv/tb_clkgen.sv
/*
  Testbench clock and reset source. Runs a 10 ns clock and holds the
  active-low reset for the first 8 cycles, releasing it on a falling edge.
*/
module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- dv/tb_snoop_subsys.sv
/*
  Directed testbench for the snoop side of the data cache. Fills lines
  through the fill port, issues snoops on AC and predicts CR, CD and the
  invalidate notice from a line model kept here. Monitors compare every
  transfer against the predictions in order.
*/
module tb_snoop_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import snoop_pkg::*;

  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 2;

  logic                   clk;
  logic                   rst_n;
  logic                   ac_valid;
  ac_req_t                ac_req;
  logic                   ac_ready;
  logic                   cr_valid;
  cr_resp_t               cr_resp;
  logic                   cr_ready;
  logic                   cd_valid;
  cd_beat_t               cd_beat;
  logic                   cd_ready;
  fill_req_t              fill;
  logic                   local_busy;
  logic [LINE_ADDR_W-1:0] local_line;
  inv_note_t              inv_note;
  logic                   bypass;

  // line model, one entry per set and way
  logic                   m_valid  [NUM_SETS][NUM_WAYS];
  logic [LINE_ADDR_W-1:0] m_line   [NUM_SETS][NUM_WAYS];
  logic [LINE_W-1:0]      m_data   [NUM_SETS][NUM_WAYS];
  logic                   m_dirty  [NUM_SETS][NUM_WAYS];
  logic                   m_shared [NUM_SETS][NUM_WAYS];

  cr_resp_t  exp_cr[$];
  cd_beat_t  exp_cd[$];
  inv_note_t exp_inv[$];

  int          seed = 32'h13ce;
  logic [31:0] ready_rnd;
  logic        stall_en;
  int          issued;
  int          cycles;
  int          cr_errs;
  int          cd_errs;
  int          inv_errs;
  int          misc_errs;

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  snoop_subsys_top #(
    .NUM_SETS (NUM_SETS),
    .NUM_WAYS (NUM_WAYS)
  ) u_snoop_subsys_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .ac_valid_i   (ac_valid),
    .ac_i         (ac_req),
    .ac_ready_o   (ac_ready),
    .cr_valid_o   (cr_valid),
    .cr_o         (cr_resp),
    .cr_ready_i   (cr_ready),
    .cd_valid_o   (cd_valid),
    .cd_o         (cd_beat),
    .cd_ready_i   (cd_ready),
    .fill_i       (fill),
    .local_busy_i (local_busy),
    .local_line_i (local_line),
    .inv_o        (inv_note),
    .bypass_i     (bypass)
  );

  task automatic check_cr(input cr_resp_t got, input cr_resp_t exp);
    if (got !== exp) begin
      $display("** Error: cr_o got %h expected %h at %0t", got, exp, $time);
      cr_errs++;
    end
  endtask

  task automatic check_cd(input cd_beat_t got, input cd_beat_t exp);
    if (got !== exp) begin
      $display("** Error: cd_o got %h expected %h at %0t", got, exp, $time);
      cd_errs++;
    end
  endtask

  task automatic check_inv(input inv_note_t got, input inv_note_t exp);
    if (got !== exp) begin
      $display("** Error: inv_o got %h expected %h at %0t", got, exp, $time);
      inv_errs++;
    end
  endtask

  function automatic int find_way(input logic [LINE_ADDR_W-1:0] la);
    int s;
    int hit_w;
    s = la % NUM_SETS;
    hit_w = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[s][w] && m_line[s][w] == la) begin
        hit_w = w;
      end
    end
    return hit_w;
  endfunction

  task automatic fill_line(input logic [LINE_ADDR_W-1:0] la, input int way,
                           input logic dirty, input logic shared);
    logic [LINE_W-1:0] d;
    int                s;
    d = {$random(seed), $random(seed), $random(seed), $random(seed)};
    s = la % NUM_SETS;
    @(negedge clk);
    fill.valid     = 1'b1;
    fill.line_addr = la;
    fill.way       = 8'(way);
    fill.data      = d;
    fill.dirty     = dirty;
    fill.shared    = shared;
    @(negedge clk);
    fill.valid         = 1'b0;
    m_valid[s][way]    = 1'b1;
    m_line[s][way]     = la;
    m_data[s][way]     = d;
    m_dirty[s][way]    = dirty;
    m_shared[s][way]   = shared;
  endtask

  // expected CR, CD beats and notice, then the state change
  task automatic predict_snoop(input logic [3:0] code, input logic [LINE_ADDR_W-1:0] la,
                               input logic byp);
    cr_resp_t  r;
    cd_beat_t  b;
    inv_note_t n;
    int        s;
    int        w;
    logic      kill;
    r    = '0;
    kill = 1'b0;
    s    = la % NUM_SETS;
    w    = find_way(la);
    if (!byp) begin
      if (!(code inside {SNP_READ_ONCE, SNP_READ_SHARED, SNP_READ_UNIQUE,
                         SNP_CLEAN_INVALID})) begin
        r.error = 1'b1;
      end else if (w >= 0) begin
        case (code)
          SNP_READ_ONCE: begin
            r.data_transfer = 1'b1;
            r.is_shared     = m_shared[s][w];
          end
          SNP_READ_SHARED: begin
            r.data_transfer = 1'b1;
            r.is_shared     = 1'b1;
            m_shared[s][w]  = 1'b1;
          end
          SNP_READ_UNIQUE: begin
            r.data_transfer = 1'b1;
            r.pass_dirty    = m_dirty[s][w];
            kill            = 1'b1;
          end
          default: begin
            r.data_transfer = m_dirty[s][w];
            r.pass_dirty    = m_dirty[s][w];
            kill            = 1'b1;
          end
        endcase
      end
    end
    exp_cr.push_back(r);
    if (r.data_transfer) begin
      b.data = m_data[s][w][BEAT_W-1:0];
      b.last = 1'b0;
      exp_cd.push_back(b);
      b.data = m_data[s][w][LINE_W-1:BEAT_W];
      b.last = 1'b1;
      exp_cd.push_back(b);
    end
    if (kill) begin
      n.valid     = 1'b1;
      n.line_addr = la;
      exp_inv.push_back(n);
      m_valid[s][w]  = 1'b0;
      m_dirty[s][w]  = 1'b0;
      m_shared[s][w] = 1'b0;
    end
  endtask

  task automatic drive_snoop(input logic [3:0] code, input logic [LINE_ADDR_W-1:0] la,
                             input logic byp);
    @(negedge clk);
    ac_valid                  = 1'b1;
    ac_req.addr.line.line_addr = la;
    ac_req.addr.line.offset    = 4'($random(seed));
    ac_req.snoop               = snoop_e'(code);
    bypass                     = byp;
    predict_snoop(code, la, byp);
    issued++;
  endtask

  task automatic await_accept();
    @(posedge clk);
    while (ac_ready !== 1'b1) begin
      @(posedge clk);
    end
  endtask

  task automatic issue_snoop(input logic [3:0] code, input logic [LINE_ADDR_W-1:0] la,
                             input logic byp);
    drive_snoop(code, la, byp);
    await_accept();
  endtask

  task automatic wait_idle();
    @(negedge clk);
    ac_valid = 1'b0;
    bypass   = 1'b0;
    while (exp_cr.size() != 0 || exp_cd.size() != 0 || exp_inv.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // A and B share set 0 in different ways
  task automatic read_once_lines();
    fill_line(28'h0000120, 0, 1'b0, 1'b0);
    fill_line(28'h0000348, 1, 1'b0, 1'b1);
    issue_snoop(SNP_READ_ONCE, 28'h0000120, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0000348, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0000120, 1'b0);
    wait_idle();
  endtask

  task automatic read_shared_upgrade();
    fill_line(28'h0000561, 0, 1'b0, 1'b0);
    issue_snoop(SNP_READ_SHARED, 28'h0000561, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0000561, 1'b0);
    wait_idle();
  endtask

  task automatic read_unique_dirty();
    fill_line(28'h0000782, 1, 1'b1, 1'b0);
    issue_snoop(SNP_READ_UNIQUE, 28'h0000782, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0000782, 1'b0);
    wait_idle();
  endtask

  // last one misses in set 3 with a tag never filled
  task automatic clean_invalid_lines();
    fill_line(28'h00009a3, 0, 1'b0, 1'b0);
    fill_line(28'h0000bc3, 1, 1'b1, 1'b1);
    issue_snoop(SNP_CLEAN_INVALID, 28'h00009a3, 1'b0);
    issue_snoop(SNP_CLEAN_INVALID, 28'h0000bc3, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h00009a3, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0000dd3, 1'b0);
    wait_idle();
  endtask

  task automatic unsupported_and_bypass();
    fill_line(28'h0000e04, 0, 1'b1, 1'b0);
    issue_snoop(4'b0010, 28'h0000e04, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0000e04, 1'b0);
    issue_snoop(SNP_READ_SHARED, 28'h0000e04, 1'b1);
    issue_snoop(SNP_READ_ONCE, 28'h0000e04, 1'b0);
    wait_idle();
  endtask

  // stall enable changes on a rising edge, away from the ready driver
  task automatic backpressure_burst();
    fill_line(28'h0001005, 0, 1'b0, 1'b0);
    fill_line(28'h0001105, 1, 1'b1, 1'b0);
    fill_line(28'h0001206, 0, 1'b1, 1'b1);
    fill_line(28'h0001307, 0, 1'b1, 1'b0);
    @(posedge clk);
    stall_en = 1'b1;
    issue_snoop(SNP_READ_ONCE, 28'h0001005, 1'b0);
    issue_snoop(SNP_READ_SHARED, 28'h0001105, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0001105, 1'b0);
    issue_snoop(SNP_READ_UNIQUE, 28'h0001206, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0001206, 1'b0);
    issue_snoop(SNP_CLEAN_INVALID, 28'h0001307, 1'b0);
    issue_snoop(SNP_READ_ONCE, 28'h0001005, 1'b0);
    issue_snoop(SNP_CLEAN_INVALID, 28'h0001005, 1'b0);
    wait_idle();
    @(posedge clk);
    stall_en = 1'b0;
  endtask

  task automatic local_conflict_hold();
    fill_line(28'h0001406, 1, 1'b0, 1'b1);
    @(negedge clk);
    local_busy = 1'b1;
    local_line = 28'h0001406;
    drive_snoop(SNP_READ_ONCE, 28'h0001406, 1'b0);
    repeat (6) begin
      @(posedge clk);
      if (ac_ready !== 1'b0) begin
        $display("** Error: ac_ready_o got %h expected 0 at %0t", ac_ready, $time);
        misc_errs++;
      end
    end
    @(negedge clk);
    local_busy = 1'b0;
    await_accept();
    wait_idle();
  endtask

  // random holds on CR and CD while stalling is enabled
  always @(negedge clk) begin
    if (stall_en) begin
      ready_rnd = $random(seed);
      cr_ready  = ready_rnd[0];
      cd_ready  = ready_rnd[1];
    end else begin
      cr_ready = 1'b1;
      cd_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (rst_n && cr_valid && cr_ready) begin
      if (exp_cr.size() == 0) begin
        $display("CR response arrived at %0t with none outstanding", $time);
        misc_errs++;
      end else begin
        check_cr(cr_resp, exp_cr.pop_front());
      end
    end
    if (rst_n && cd_valid && cd_ready) begin
      if (exp_cd.size() == 0) begin
        $display("CD beat arrived at %0t with no data expected", $time);
        misc_errs++;
      end else begin
        check_cd(cd_beat, exp_cd.pop_front());
      end
    end
    if (rst_n && inv_note.valid) begin
      if (exp_inv.size() == 0) begin
        $display("invalidate notice at %0t with no invalidation expected", $time);
        misc_errs++;
      end else begin
        check_inv(inv_note, exp_inv.pop_front());
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < 40 * issued + 200) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d snoops issued", cycles, issued);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    ac_valid   = 1'b0;
    ac_req     = '0;
    cr_ready   = 1'b1;
    cd_ready   = 1'b1;
    fill       = '0;
    local_busy = 1'b0;
    local_line = '0;
    bypass     = 1'b0;
    stall_en   = 1'b0;
    issued     = 0;
    cr_errs    = 0;
    cd_errs    = 0;
    inv_errs   = 0;
    misc_errs  = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
    @(posedge rst_n);
    read_once_lines();
    read_shared_upgrade();
    read_unique_dirty();
    clean_invalid_lines();
    unsupported_and_bypass();
    backpressure_burst();
    local_conflict_hold();
    repeat (5) @(negedge clk);
    $display("summary: %0d snoops, errors cr=%0d cd=%0d inv=%0d other=%0d",
             issued, cr_errs, cd_errs, inv_errs, misc_errs);
    if (cr_errs + cd_errs + inv_errs + misc_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
verilog/snoop_pkg.sv
verilog/snoop_accept.sv
verilog/cache_store.sv
verilog/snoop_eval.sv
verilog/snoop_resp.sv
verilog/snoop_subsys_top.sv
dv/tb_clkgen.sv
dv/tb_snoop_subsys.sv
